// File: verif/cache_trace.txt
# op addr wstrb wdata expected, all hex
# op 1 is a store, expected is the load result and zero for stores
0 00000104 0 00000000 c0de0041
0 0000010c 0 00000000 c0de0043
1 00000108 f deadbeef 00000000
0 00000108 0 00000000 deadbeef
1 00000100 3 0000abcd 00000000
0 00000100 0 00000000 c0deabcd
0 00001104 0 00000000 c0de0441
1 0000110c c 12340000 00000000
0 00000104 0 00000000 c0de0041
# third tag in set 10, evictions from here on
0 00002108 0 00000000 c0de0842
0 0000110c 0 00000000 12340443
0 00000108 0 00000000 deadbeef
0 00000100 0 00000000 c0deabcd
1 00003104 1 000000ee 00000000
0 00003104 0 00000000 c0de0cee
0 00003100 0 00000000 c0de0c40
1 00002100 f 11112222 00000000
0 00000104 0 00000000 c0de0041
0 00003104 0 00000000 c0de0cee
0 00002100 0 00000000 11112222
# set 20
1 00000204 6 00aabb00 00000000
0 00000204 0 00000000 c0aabb81
0 0000520c 0 00000000 c0de1483
1 00005200 8 7f000000 00000000
0 00009200 0 00000000 c0de2480
0 00000204 0 00000000 c0aabb81
0 00005200 0 00000000 7fde1480
0 00005200 0 00000000 7fde1480
# last set
0 0000fff8 0 00000000 c0de3ffe
1 0000fffc f 5a5a5a5a 00000000
0 0000fffc 0 00000000 5a5a5a5a

// File: cache.f
src/cache_pkg.sv
src/sp_ram.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_top.sv
verif/cache_chk.sv
verif/cache_tb.sv

// File: Makefile
TOP = cache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cache.f --top-module $(TOP)

obj_dir/V$(TOP): cache.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --assert -j 0 -f cache.f --top-module $(TOP)

# the log decides pass or fail
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

    localparam logic [31:0] INIT_KEY = 32'hc0de_0000;
    localparam int          MAX_WAIT = 400;

    logic                clk_g;
    logic                rst;
    logic                valid;
    cache_pkg::cpu_req_t req;
    logic                addr_ok;
    logic                data_ok;
    logic [31:0]         rdata;
    logic                rd_req;
    logic [31:0]         rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         ret_data;
    logic                wr_req;
    logic [31:0]         wr_addr;
    cache_pkg::line_t    wr_data;
    logic                wr_rdy;

    integer      seed = 95;
    // words changed by write-backs, keyed by byte address
    logic [31:0] mem [int unsigned];
    // latest stored word per address, as the processor sees it
    logic [31:0] stored [int unsigned];
    // resident lines per set, slot 0 used most recently
    logic [31:0] res_line  [cache_pkg::NUM_SETS][2];
    bit          res_valid [cache_pkg::NUM_SETS][2];
    bit          res_dirty [cache_pkg::NUM_SETS][2];
    logic [31:0] cur_addr;
    logic [31:0] wb_addr;
    bit          wb_due;
    bit          saw_rd;
    bit          saw_wb;

    cache_top dut (.*);

    initial begin
        clk_g = 1'b0;
        forever #4 clk_g = ~clk_g;
    end

    function automatic logic [31:0] init_word(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ INIT_KEY;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        if (mem.exists(byte_addr)) begin
            return mem[byte_addr];
        end
        return init_word(byte_addr);
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] byte_addr);
        if (stored.exists(byte_addr)) begin
            return stored[byte_addr];
        end
        return init_word(byte_addr);
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // ready about three times in four
    function automatic bit random_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic accept_writeback();
        logic [31:0] word_addr;
        assert (wb_due && !saw_wb) else begin
            stop_run("write-back issued when no dirty line was due for eviction");
        end
        check_value("wr_addr", wr_addr, wb_addr);
        saw_wb = 1'b1;
        for (int w = 0; w < 4; w++) begin
            word_addr = wr_addr + 32'(4 * w);
            check_value($sformatf("wr_data[%0d]", w), wr_data[w], ref_word(word_addr));
            mem[word_addr] = wr_data[w];
        end
    endtask

    initial begin : memory_model
        int          beats;
        bit          refill_on;
        logic [31:0] line_addr;
        beats     = 0;
        refill_on = 1'b0;
        line_addr = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk_g);
            rd_rdy    = 1'b0;
            wr_rdy    = 1'b0;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            if (refill_on) begin
                if (random_ready()) begin
                    ret_valid = 1'b1;
                    ret_data  = mem_word(line_addr + 32'(4 * beats));
                    ret_last  = (beats == 3);
                    beats++;
                    refill_on = (beats < 4);
                end
            end else if (wr_req && random_ready()) begin
                wr_rdy = 1'b1;
                accept_writeback();
            end else if (rd_req && random_ready()) begin
                rd_rdy = 1'b1;
                saw_rd = 1'b1;
                check_value("rd_addr", rd_addr, {cur_addr[31:4], 4'h0});
                line_addr = rd_addr;
                beats     = 0;
                refill_on = 1'b1;
            end
        end
    end

    // entered and left just after a falling edge
    task automatic run_access(input logic op, input logic [31:0] addr,
                              input logic [3:0] strb, input logic [31:0] wdata,
                              input logic [31:0] exp);
        int                waited;
        int                slot;
        bit                expect_hit;
        bit                dirty_keep;
        cache_pkg::index_t set_idx;
        logic [31:0]       line_addr;
        logic [31:0]       word_addr;
        line_addr = {addr[31:4], 4'h0};
        word_addr = {addr[31:2], 2'b00};
        set_idx   = addr[11:4];
        slot      = -1;
        for (int s = 0; s < 2; s++) begin
            if (res_valid[set_idx][s] && res_line[set_idx][s] == line_addr) begin
                slot = s;
            end
        end
        expect_hit = (slot >= 0);
        // a miss in a full set evicts the least recent line
        wb_due   = !expect_hit && res_valid[set_idx][1] && res_dirty[set_idx][1];
        wb_addr  = res_line[set_idx][1];
        cur_addr = addr;
        saw_rd   = 1'b0;
        saw_wb   = 1'b0;
        valid    = 1'b1;
        req = '{op: op, tag: addr[31:12], index: addr[11:4], offset: addr[3:0],
                wstrb: strb, wdata: wdata};
        waited = 0;
        while (!addr_ok) begin
            @(negedge clk_g);
            waited++;
            assert (waited <= MAX_WAIT) else stop_run("timeout waiting for addr_ok");
        end
        @(negedge clk_g);
        valid  = 1'b0;
        waited = 1;
        while (!data_ok) begin
            @(negedge clk_g);
            waited++;
            assert (waited <= MAX_WAIT) else stop_run("timeout waiting for data_ok");
        end
        if (!op) begin
            check_value("rdata", rdata, exp);
        end else begin
            stored[word_addr] = store_merge(ref_word(word_addr), wdata, strb);
        end
        if (expect_hit) begin
            check_value("data_ok latency", 32'(waited), 32'd1);
            assert (!saw_rd) else stop_run("rd_req issued for a line that should hit");
        end else begin
            assert (saw_rd) else stop_run("no rd_req for a line that should miss");
        end
        assert (saw_wb || !wb_due) else stop_run("no write-back for the evicted dirty line");
        // hit in slot 1 swaps, a miss pushes slot 0 down
        if (slot != 0) begin
            dirty_keep            = (slot == 1) ? res_dirty[set_idx][1] : 1'b0;
            res_line[set_idx][1]  = res_line[set_idx][0];
            res_valid[set_idx][1] = res_valid[set_idx][0];
            res_dirty[set_idx][1] = res_dirty[set_idx][0];
            res_line[set_idx][0]  = line_addr;
            res_valid[set_idx][0] = 1'b1;
            res_dirty[set_idx][0] = dirty_keep;
        end
        res_dirty[set_idx][0] = res_dirty[set_idx][0] | op;
    endtask

    initial begin : stimulus
        int          fd;
        int          code;
        int          count;
        string       text;
        logic [31:0] t_op;
        logic [31:0] t_addr;
        logic [31:0] t_strb;
        logic [31:0] t_wdata;
        logic [31:0] t_exp;
        rst   = 1'b1;
        valid = 1'b0;
        req   = '0;
        count = 0;
        repeat (4) @(negedge clk_g);
        rst = 1'b0;
        check_value("addr_ok", 32'(addr_ok), 32'd1);
        check_value("data_ok", 32'(data_ok), 32'd0);
        check_value("rd_req", 32'(rd_req), 32'd0);
        check_value("wr_req", 32'(wr_req), 32'd0);
        fd = $fopen("verif/cache_trace.txt", "r");
        assert (fd != 0) else stop_run("cannot open verif/cache_trace.txt");
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text.substr(0, 0) != "#") begin
                code = $sscanf(text, "%h %h %h %h %h", t_op, t_addr, t_strb, t_wdata, t_exp);
                assert (code == 5) else stop_run($sformatf("malformed trace line: %s", text));
                run_access(t_op[0], t_addr, t_strb[3:0], t_wdata, t_exp);
                count++;
            end
        end
        $fclose(fd);
        assert (count > 0) else stop_run("the trace held no accesses");
        $display("sim passed");
        $finish;
    end

endmodule

// File: verif/cache_chk.sv
`timescale 1ns/1ns

module cache_chk (
    input logic                   clk_g,
    input logic                   rst,
    input cache_pkg::ctrl_state_t state,
    input logic                   valid,
    input logic                   addr_ok,
    input logic                   data_ok,
    input logic [1:0]             hit,
    input logic                   rd_req,
    input logic                   rd_rdy,
    input logic [31:0]            rd_addr,
    input logic                   wr_req,
    input logic                   wr_rdy,
    input logic [31:0]            wr_addr
);

    // one cycle done pulse, then ready for the next request
    data_ok_pulse: assert property (@(posedge clk_g) disable iff (rst)
        data_ok |=> !data_ok && addr_ok)
        else $error("data_ok longer than one cycle or cache not ready after it");

    // request levels and their address stay put until ready
    rd_req_held: assert property (@(posedge clk_g) disable iff (rst)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("rd_req or rd_addr changed before rd_rdy");

    wr_req_held: assert property (@(posedge clk_g) disable iff (rst)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
        else $error("wr_req or wr_addr changed before wr_rdy");

    single_way_hit: assert property (@(posedge clk_g) disable iff (rst)
        !(hit[0] && hit[1]))
        else $error("both ways hit the same request");

    // one request in flight, acceptance starts the lookup
    accept_to_lookup: assert property (@(posedge clk_g) disable iff (rst)
        valid && addr_ok |=> state == cache_pkg::LOOKUP)
        else $error("accepted request did not start a lookup");

endmodule

bind cache_ctrl cache_chk chk (
    .clk_g   (clk_g),
    .rst     (rst),
    .state   (state),
    .valid   (valid),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .hit     (hit),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_addr (rd_addr),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy),
    .wr_addr (wr_addr)
);

// File: src/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                clk_g,
    input  logic                rst,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         ret_data,
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    cache_pkg::index_t           index;
    cache_pkg::tag_t             req_tag;
    cache_pkg::way_sel_t         tag_we;
    cache_pkg::tag_entry_t       tag_wdata;
    logic [1:0][3:0]             bank_we;
    cache_pkg::line_t            bank_wdata;
    logic [15:0]                 bank_wstrb;
    cache_pkg::way_sel_t         dirty_set;
    cache_pkg::way_sel_t         dirty_clr;
    logic [1:0]                  hit;
    cache_pkg::tag_entry_t [1:0] entry;
    logic [1:0]                  dirty;
    cache_pkg::line_t [1:0]      line;

    cache_way way0 (
        .clk_g      (clk_g),
        .rst        (rst),
        .index      (index),
        .req_tag    (req_tag),
        .tag_we     (tag_we[0]),
        .tag_wdata  (tag_wdata),
        .bank_we    (bank_we[0]),
        .bank_wdata (bank_wdata),
        .bank_wstrb (bank_wstrb),
        .dirty_set  (dirty_set[0]),
        .dirty_clr  (dirty_clr[0]),
        .hit        (hit[0]),
        .entry      (entry[0]),
        .dirty      (dirty[0]),
        .line       (line[0])
    );

    cache_way way1 (
        .clk_g      (clk_g),
        .rst        (rst),
        .index      (index),
        .req_tag    (req_tag),
        .tag_we     (tag_we[1]),
        .tag_wdata  (tag_wdata),
        .bank_we    (bank_we[1]),
        .bank_wdata (bank_wdata),
        .bank_wstrb (bank_wstrb),
        .dirty_set  (dirty_set[1]),
        .dirty_clr  (dirty_clr[1]),
        .hit        (hit[1]),
        .entry      (entry[1]),
        .dirty      (dirty[1]),
        .line       (line[1])
    );

    // write enables arrive already gated per way
    cache_ctrl ctrl (
        .clk_g      (clk_g),
        .rst        (rst),
        .valid      (valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .index      (index),
        .req_tag    (req_tag),
        .way_sel    (),
        .tag_we     (tag_we),
        .tag_wdata  (tag_wdata),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .bank_wstrb (bank_wstrb),
        .dirty_set  (dirty_set),
        .dirty_clr  (dirty_clr),
        .hit        (hit),
        .entry      (entry),
        .dirty      (dirty),
        .line       (line),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy)
    );

endmodule

// File: src/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                        clk_g,
    input  logic                        rst,
    input  logic                        valid,
    input  cache_pkg::cpu_req_t         req,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [31:0]                 rdata,
    output cache_pkg::index_t           index,
    output cache_pkg::tag_t             req_tag,
    output cache_pkg::way_sel_t         way_sel,
    output cache_pkg::way_sel_t         tag_we,
    output cache_pkg::tag_entry_t       tag_wdata,
    output logic [1:0][3:0]             bank_we,
    output cache_pkg::line_t            bank_wdata,
    output logic [15:0]                 bank_wstrb,
    output cache_pkg::way_sel_t         dirty_set,
    output cache_pkg::way_sel_t         dirty_clr,
    input  logic [1:0]                  hit,
    input  cache_pkg::tag_entry_t [1:0] entry,
    input  logic [1:0]                  dirty,
    input  cache_pkg::line_t [1:0]      line,
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [31:0]                 ret_data,
    output logic                        wr_req,
    output logic [31:0]                 wr_addr,
    output cache_pkg::line_t            wr_data,
    input  logic                        wr_rdy
);

    cache_pkg::ctrl_state_t         state;
    cache_pkg::ctrl_state_t         state_nxt;
    cache_pkg::cpu_req_t            req_buf;
    // set when way 1 was used last
    logic [cache_pkg::NUM_SETS-1:0] lru;
    cache_pkg::way_sel_t            victim;
    cache_pkg::way_sel_t            victim_r;
    cache_pkg::tag_entry_t          victim_entry;
    logic                           victim_dirty;
    logic                           cache_hit;
    logic                           store_hit;
    logic                           refill_beat;
    logic                           refill_done;
    logic [1:0]                     refill_cnt;
    logic [1:0]                     word_sel;
    cache_pkg::line_t               hit_line;
    logic [31:0]                    hit_word;
    logic [31:0]                    refill_word;
    logic [31:0]                    miss_word;

    assign word_sel  = req_buf.offset[3:2];
    assign addr_ok   = (state == cache_pkg::IDLE);
    // incoming index in IDLE so the RAMs are ready in LOOKUP
    assign index     = addr_ok ? req.index : req_buf.index;
    assign req_tag   = req_buf.tag;
    assign cache_hit = |hit;
    assign store_hit = (state == cache_pkg::LOOKUP) && cache_hit && req_buf.op;

    assign hit_line = hit[1] ? line[1] : line[0];
    assign hit_word = hit_line[word_sel];

    // first invalid way, else the least recent one
    always_comb begin
        if (!entry[0].valid) begin
            victim = 2'b01;
        end else if (!entry[1].valid) begin
            victim = 2'b10;
        end else if (lru[req_buf.index]) begin
            victim = 2'b01;
        end else begin
            victim = 2'b10;
        end
    end

    assign way_sel = (state == cache_pkg::LOOKUP) ? hit : victim_r;

    assign victim_entry = victim_r[1] ? entry[1] : entry[0];
    assign victim_dirty = victim_r[1] ? dirty[1] : dirty[0];

    assign wr_req  = (state == cache_pkg::MISS) && victim_entry.valid && victim_dirty;
    assign wr_addr = {victim_entry.tag, req_buf.index, 4'b0000};
    assign wr_data = victim_r[1] ? line[1] : line[0];
    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_buf.tag, req_buf.index, 4'b0000};

    assign refill_beat = (state == cache_pkg::REFILL) && ret_valid && !refill_done;
    // store bytes go straight into the returning word
    assign refill_word = (req_buf.op && refill_cnt == word_sel)
                       ? cache_pkg::merge_bytes(ret_data, req_buf.wdata, req_buf.wstrb)
                       : ret_data;

    assign data_ok = ((state == cache_pkg::LOOKUP) && cache_hit)
                   || ((state == cache_pkg::REFILL) && refill_done);
    assign rdata   = (state == cache_pkg::REFILL) ? miss_word : hit_word;

    always_comb begin
        tag_we     = '0;
        bank_we    = '0;
        dirty_set  = '0;
        dirty_clr  = '0;
        tag_wdata  = '{valid: 1'b1, tag: req_buf.tag};
        bank_wdata = {4{req_buf.wdata}};
        bank_wstrb = 16'(req_buf.wstrb) << {word_sel, 2'b00};
        if (store_hit) begin
            bank_we[0][word_sel] = way_sel[0];
            bank_we[1][word_sel] = way_sel[1];
            dirty_set            = way_sel;
        end else if (refill_beat) begin
            bank_wdata             = {4{refill_word}};
            bank_wstrb             = '1;
            bank_we[0][refill_cnt] = way_sel[0];
            bank_we[1][refill_cnt] = way_sel[1];
            if (ret_last) begin
                tag_we = way_sel;
                if (req_buf.op) begin
                    dirty_set = way_sel;
                end else begin
                    dirty_clr = way_sel;
                end
            end
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            cache_pkg::IDLE:    if (valid) state_nxt = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP:  state_nxt = cache_hit ? cache_pkg::IDLE : cache_pkg::MISS;
            // clean or invalid victim skips the write-back
            cache_pkg::MISS:    if (!wr_req || wr_rdy) state_nxt = cache_pkg::REPLACE;
            cache_pkg::REPLACE: if (rd_rdy) state_nxt = cache_pkg::REFILL;
            cache_pkg::REFILL:  if (refill_done) state_nxt = cache_pkg::IDLE;
            default:            state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_g) begin
        if (rst) begin
            state       <= cache_pkg::IDLE;
            victim_r    <= 2'b01;
            refill_cnt  <= 2'd0;
            refill_done <= 1'b0;
            lru         <= '0;
        end else begin
            state <= state_nxt;
            if (state == cache_pkg::LOOKUP && !cache_hit) begin
                victim_r <= victim;
            end
            if (state == cache_pkg::REPLACE) begin
                refill_cnt  <= 2'd0;
                refill_done <= 1'b0;
            end else if (refill_beat) begin
                refill_cnt  <= refill_cnt + 2'd1;
                refill_done <= ret_last;
            end
            // finished access marks its way most recent
            if (data_ok) begin
                lru[req_buf.index] <= way_sel[1];
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (valid && addr_ok) begin
            req_buf <= req;
        end
        if (refill_beat && refill_cnt == word_sel) begin
            miss_word <= refill_word;
        end
    end

endmodule

// File: src/cache_way.sv
`timescale 1ns/1ns

module cache_way (
    input  logic                  clk_g,
    input  logic                  rst,
    input  cache_pkg::index_t     index,
    input  cache_pkg::tag_t       req_tag,
    input  logic                  tag_we,
    input  cache_pkg::tag_entry_t tag_wdata,
    input  logic [3:0]            bank_we,
    input  cache_pkg::line_t      bank_wdata,
    input  logic [15:0]           bank_wstrb,
    input  logic                  dirty_set,
    input  logic                  dirty_clr,
    output logic                  hit,
    output cache_pkg::tag_entry_t entry,
    output logic                  dirty,
    output cache_pkg::line_t      line
);

    logic [cache_pkg::NUM_SETS-1:0] valid_bits;
    logic [cache_pkg::NUM_SETS-1:0] dirty_bits;
    logic                           valid_q;
    cache_pkg::tag_entry_t          tag_rd;
    cache_pkg::line_t               bank_wr;

    sp_ram #(
        .DEPTH  (cache_pkg::NUM_SETS),
        .elem_t (cache_pkg::tag_entry_t)
    ) tag_ram (
        .clk_g (clk_g),
        .we    (tag_we),
        .addr  (index),
        .wdata (tag_wdata),
        .rdata (tag_rd)
    );

    // valid and dirty read with the same one cycle latency as the RAMs
    always_ff @(posedge clk_g) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty      <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_bits[index] <= tag_wdata.valid;
            end
            if (dirty_set) begin
                dirty_bits[index] <= 1'b1;
            end else if (dirty_clr) begin
                dirty_bits[index] <= 1'b0;
            end
            valid_q <= valid_bits[index];
            dirty   <= dirty_bits[index];
        end
    end

    // register masks stale RAM contents after reset
    assign entry = '{valid: valid_q & tag_rd.valid, tag: tag_rd.tag};
    assign hit   = entry.valid && (entry.tag == req_tag);

    for (genvar i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin : g_bank
        // unstrobed bytes keep what the bank holds
        assign bank_wr[i] = cache_pkg::merge_bytes(line[i], bank_wdata[i],
                                                   bank_wstrb[4*i +: 4]);

        sp_ram #(
            .DEPTH  (cache_pkg::NUM_SETS),
            .elem_t (logic [31:0])
        ) data_ram (
            .clk_g (clk_g),
            .we    (bank_we[i]),
            .addr  (index),
            .wdata (bank_wr[i]),
            .rdata (line[i])
        );
    end

endmodule

// File: src/sp_ram.sv
`timescale 1ns/1ns

module sp_ram #(
    parameter int  DEPTH  = 256,
    parameter type elem_t = logic [31:0]
) (
    input  logic              clk_g,
    input  logic              we,
    input  cache_pkg::index_t addr,
    input  elem_t             wdata,
    output elem_t             rdata
);

    elem_t mem [DEPTH];

    // old contents come out on a write to the same address
    always_ff @(posedge clk_g) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [7:0]  index_t;
    typedef logic [19:0] tag_t;
    // bits 3:2 pick the word
    typedef logic [3:0]  offset_t;

    typedef struct packed {
        logic        op;
        tag_t        tag;
        index_t      index;
        offset_t     offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

    typedef logic [1:0] way_sel_t;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } ctrl_state_t;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return merged;
    endfunction

endpackage
